// ==== logic/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// address and data path width
`define FETCH_ADDR_W 32

// four lines
`define FETCH_IDX_BITS 2

// two words per line
`define FETCH_LINE_BITS 1

`define FETCH_PC_INIT 32'h0000_0000

`endif

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_LUI      = 7'b0110111,
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_LOAD     = 7'b0000011,
    OP_STORE    = 7'b0100011,
    OP_MISC_MEM = 7'b0001111,
    OP_SYSTEM   = 7'b1110011,
    OP_OP       = 7'b0110011,
    OP_OP_IMM   = 7'b0010011
  } opcode_e;

  // fence.i is misc-mem with funct3 001 and all other fields zero
  localparam logic [31:0] INST_FENCE_I = 32'h0000_100f;

  typedef struct packed {
    logic is_branch;
    logic is_cond;
    logic is_load;
    logic is_store;
    logic is_fence;
  } inst_class_t;

endpackage

// ==== logic/fetch_pkg.sv ====
`include "fetch_settings.svh"

package fetch_pkg;

  // single word read, address word aligned
  typedef struct packed {
    logic                     valid;
    logic [`FETCH_ADDR_W-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic                     valid;
    logic [`FETCH_ADDR_W-1:0] data;
  } mem_rsp_t;

  // redirect clear means fall through to pc + 4
  typedef struct packed {
    logic                     valid;
    logic                     redirect;
    logic [`FETCH_ADDR_W-1:0] target;
  } resolve_t;

  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-1:0] inst;
    logic                     spec;
  } fetch_out_t;

  typedef enum logic [2:0] {
    IDLE,
    REQ0,
    WAIT0,
    REQ1,
    WAIT1,
    DONE
  } cache_state_e;

  typedef enum logic [1:0] {
    RUN,
    HAZARD,
    SPEC,
    FLUSH
  } ctrl_state_e;

endpackage

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_decode (
  input  logic [`FETCH_ADDR_W-1:0] inst_i,
  output rv_isa_pkg::inst_class_t  class_o
);
  import rv_isa_pkg::*;

  opcode_e opcode;

  assign opcode = opcode_e'(inst_i[6:0]);

  always_comb begin
    class_o = '0;
    case (opcode)
      // ecall and friends leave the sequential path too
      OP_JAL, OP_JALR, OP_SYSTEM: begin
        class_o.is_branch = 1'b1;
      end
      OP_BRANCH: begin
        class_o.is_branch = 1'b1;
        class_o.is_cond   = 1'b1;
      end
      OP_LOAD: begin
        class_o.is_load = 1'b1;
      end
      OP_STORE: begin
        class_o.is_store = 1'b1;
      end
      // plain fence runs through as sequential
      OP_MISC_MEM: begin
        class_o.is_fence = (inst_i == INST_FENCE_I);
      end
      default: begin
        class_o = '0;
      end
    endcase
  end

endmodule

// ==== logic/icache.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module icache (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`FETCH_ADDR_W-1:0] pc_i,
  input  logic                     inval_i,
  output fetch_pkg::mem_req_t      mem_req_o,
  input  fetch_pkg::mem_rsp_t      mem_rsp_i,
  output logic [`FETCH_ADDR_W-1:0] inst_o,
  output logic                     hit_o
);
  import fetch_pkg::*;

  localparam int AW        = `FETCH_ADDR_W;
  localparam int IDX_BITS  = `FETCH_IDX_BITS;
  localparam int LINE_BITS = `FETCH_LINE_BITS;
  localparam int LINES     = 2 ** IDX_BITS;
  localparam int WORDS     = 2 ** LINE_BITS;
  localparam int IDX_LO    = 2 + LINE_BITS;
  localparam int TAG_LO    = IDX_LO + IDX_BITS;
  localparam int TAG_W     = AW - TAG_LO;
  // tag and index together name a line
  localparam int LINE_W    = AW - IDX_LO;

  logic [AW-1:0]    data_mem [LINES][WORDS];
  logic [TAG_W-1:0] tag_mem  [LINES];
  logic [LINES-1:0] line_valid;

  cache_state_e state_q;
  logic [LINE_W-1:0] refill_line_q;

  logic [TAG_W-1:0]     pc_tag;
  logic [IDX_BITS-1:0]  pc_idx;
  logic [LINE_BITS-1:0] pc_off;
  logic [TAG_W-1:0]     refill_tag;
  logic [IDX_BITS-1:0]  refill_idx;
  logic                 miss;

  assign pc_tag = pc_i[AW-1:TAG_LO];
  assign pc_idx = pc_i[TAG_LO-1:IDX_LO];
  assign pc_off = pc_i[IDX_LO-1:2];
  assign {refill_tag, refill_idx} = refill_line_q;

  assign hit_o  = (state_q == IDLE) && line_valid[pc_idx] && (tag_mem[pc_idx] == pc_tag);
  assign miss   = (state_q == IDLE) && !hit_o;
  assign inst_o = data_mem[pc_idx][pc_off];

  // low word first, then the high word
  always_comb begin
    mem_req_o.valid = (state_q == REQ0) || (state_q == REQ1);
    mem_req_o.addr  = {refill_line_q, LINE_BITS'(state_q == REQ1), 2'b00};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= IDLE;
      line_valid <= '0;
    end else begin
      if (inval_i) begin
        line_valid <= '0;
      end
      case (state_q)
        IDLE: begin
          if (miss) begin
            state_q <= REQ0;
          end
        end
        REQ0: state_q <= WAIT0;
        WAIT0: begin
          if (mem_rsp_i.valid) begin
            state_q <= REQ1;
          end
        end
        REQ1: state_q <= WAIT1;
        WAIT1: begin
          if (mem_rsp_i.valid) begin
            state_q                <= DONE;
            line_valid[refill_idx] <= 1'b1;
          end
        end
        DONE: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // line address is latched so a redirect mid-refill can't corrupt it
  always_ff @(posedge clk) begin
    if (miss) begin
      refill_line_q <= pc_i[AW-1:IDX_LO];
    end
    if (state_q == WAIT0 && mem_rsp_i.valid) begin
      data_mem[refill_idx][0] <= mem_rsp_i.data;
    end
    if (state_q == WAIT1 && mem_rsp_i.valid) begin
      data_mem[refill_idx][1] <= mem_rsp_i.data;
      tag_mem[refill_idx]     <= refill_tag;
    end
  end

endmodule

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`FETCH_ADDR_W-1:0] inst_i,
  input  logic                     hit_i,
  input  rv_isa_pkg::inst_class_t  class_i,
  input  fetch_pkg::resolve_t      resolve_i,
  input  logic                     ready_i,
  output logic [`FETCH_ADDR_W-1:0] pc_o,
  output logic                     inval_o,
  output fetch_pkg::fetch_out_t    out_o,
  output logic                     valid_o
);
  import fetch_pkg::*;

  localparam int AW = `FETCH_ADDR_W;

  ctrl_state_e state_q;

  logic [AW-1:0] pc_q;
  logic [AW-1:0] btb_q;
  logic          btb_valid_q;
  // predicted target and fall-through of the instruction awaiting resolve
  logic [AW-1:0] pred_q;
  logic [AW-1:0] seq_npc_q;
  logic          pend_q;
  logic [AW-1:0] pend_npc_q;

  logic [AW-1:0] pc_seq;
  logic [AW-1:0] res_npc;
  logic          stall_cls;
  logic          xfer;
  logic          hold;
  logic          res_v;
  logic          res_apply;
  logic          res_match;

  assign pc_seq    = pc_q + AW'(4);
  assign stall_cls = class_i.is_branch | class_i.is_load | class_i.is_store | class_i.is_fence;

  assign valid_o = hit_i & ((state_q == RUN) | ((state_q == SPEC) & ~stall_cls));
  assign xfer    = valid_o & ready_i;
  assign hold    = valid_o & ~ready_i;

  // a resolve that lands on a held output is applied once it moves
  assign res_v     = resolve_i.valid | pend_q;
  assign res_apply = res_v & ~hold;
  assign res_match = (res_npc == pred_q);

  always_comb begin
    if (!resolve_i.valid) begin
      res_npc = pend_npc_q;
    end else if (resolve_i.redirect) begin
      res_npc = resolve_i.target;
    end else begin
      res_npc = seq_npc_q;
    end
  end

  assign pc_o      = pc_q;
  assign inval_o   = xfer & class_i.is_fence;
  assign out_o.pc   = pc_q;
  assign out_o.inst = inst_i;
  assign out_o.spec = (state_q == SPEC);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= RUN;
      pc_q        <= `FETCH_PC_INIT;
      btb_valid_q <= 1'b0;
      pend_q      <= 1'b0;
    end else begin
      pend_q <= res_v & hold;
      if (resolve_i.valid && resolve_i.redirect) begin
        btb_valid_q <= 1'b1;
      end
      case (state_q)
        RUN: begin
          if (xfer) begin
            pc_q <= pc_seq;
            if (class_i.is_branch && btb_valid_q) begin
              pc_q    <= btb_q;
              state_q <= SPEC;
            end else if (class_i.is_branch || class_i.is_load || class_i.is_fence) begin
              // prefetch the fall-through while waiting
              state_q <= HAZARD;
            end
          end
        end
        HAZARD: begin
          if (res_apply) begin
            pc_q    <= res_npc;
            state_q <= RUN;
          end
        end
        SPEC: begin
          if (xfer) begin
            pc_q <= pc_seq;
          end
          if (res_apply && !res_match) begin
            pc_q    <= res_npc;
            state_q <= FLUSH;
          end else if (res_apply) begin
            state_q <= RUN;
          end
        end
        FLUSH: state_q <= RUN;
        default: state_q <= RUN;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (resolve_i.valid && resolve_i.redirect) begin
      btb_q <= resolve_i.target;
    end
    if (resolve_i.valid) begin
      pend_npc_q <= res_npc;
    end
    if (state_q == RUN && xfer) begin
      seq_npc_q <= pc_seq;
      pred_q    <= btb_q;
    end
  end

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  output fetch_pkg::mem_req_t   mem_req_o,
  input  fetch_pkg::mem_rsp_t   mem_rsp_i,
  input  fetch_pkg::resolve_t   resolve_i,
  input  logic                  ready_i,
  output fetch_pkg::fetch_out_t out_o,
  output logic                  valid_o
);
  import rv_isa_pkg::*;

  logic [`FETCH_ADDR_W-1:0] pc;
  logic [`FETCH_ADDR_W-1:0] inst;
  logic                     inval;
  logic                     hit;
  inst_class_t              inst_class;

  fetch_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .inst_i   (inst),
    .hit_i    (hit),
    .class_i  (inst_class),
    .resolve_i(resolve_i),
    .ready_i  (ready_i),
    .pc_o     (pc),
    .inval_o  (inval),
    .out_o    (out_o),
    .valid_o  (valid_o)
  );

  icache u_icache (
    .clk      (clk),
    .rst      (rst),
    .pc_i     (pc),
    .inval_i  (inval),
    .mem_req_o(mem_req_o),
    .mem_rsp_i(mem_rsp_i),
    .inst_o   (inst),
    .hit_o    (hit)
  );

  inst_decode u_decode (
    .inst_i (inst),
    .class_o(inst_class)
  );

endmodule

// ==== sim/fetch_asserts.sv ====
`timescale 1ns/1ps

module fetch_asserts (
  input logic                    clk,
  input logic                    rst,
  input logic                    valid_i,
  input logic                    ready_i,
  input logic                    inval_i,
  input fetch_pkg::fetch_out_t   out_i,
  input rv_isa_pkg::inst_class_t class_i,
  input fetch_pkg::ctrl_state_e  state_i
);
  import fetch_pkg::*;

  // failed assertions so far
  int fail_cnt = 0;

  // a stalled output stays put
  hold_stable: assert property (@(posedge clk) disable iff (rst)
    valid_i && !ready_i |=> valid_i && $stable(out_i))
    else begin
      fail_cnt++;
      $error("fetch output changed while ready was low");
    end

  no_spec_mem: assert property (@(posedge clk) disable iff (rst)
    valid_i && out_i.spec |-> !class_i.is_load && !class_i.is_store)
    else begin
      fail_cnt++;
      $error("load or store offered under speculation");
    end

  // only an accepted branch opens a speculative window
  spec_entry: assert property (@(posedge clk) disable iff (rst)
    $rose(state_i == SPEC) |-> $past(valid_i && ready_i && class_i.is_branch))
    else begin
      fail_cnt++;
      $error("speculation entered without an accepted branch");
    end

  // a fence waits for its resolve
  fence_waits: assert property (@(posedge clk) disable iff (rst)
    inval_i |=> state_i == HAZARD)
    else begin
      fail_cnt++;
      $error("invalidate not followed by a hazard stall");
    end

endmodule

bind fetch_ctrl fetch_asserts u_asserts (
  .clk    (clk),
  .rst    (rst),
  .valid_i(valid_o),
  .ready_i(ready_i),
  .inval_i(inval_o),
  .out_i  (out_o),
  .class_i(class_i),
  .state_i(state_q)
);

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_tb;
  import fetch_pkg::*;

  localparam int N_INST = 2000;
  // two refills, a slow resolve and a flush per instruction at worst
  localparam int MAX_CYCLES = N_INST * 40;
  localparam logic [31:0] FENCE_I = 32'h0000_100f;

  logic       clk;
  logic       rst;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp = '0;
  resolve_t   resolve = '0;
  logic       ready = 1'b0;
  fetch_out_t dut_out;
  logic       valid;

  logic [31:0] mem [256];
  integer      seed = 32'h4d34f2b8;
  int          errors = 0;
  int          checks = 0;
  int          accepted = 0;
  int          rewrites = 0;
  int          cycles = 0;

  bit          rsp_busy = 1'b0;
  int          rsp_cnt = 0;
  logic [31:0] rsp_addr = '0;

  // reference model
  logic [31:0] arch_pc = `FETCH_PC_INIT;
  logic [31:0] spec_pc = '0;
  logic [31:0] pred = '0;
  logic [31:0] btb = '0;
  bit          btb_valid = 1'b0;
  bit          spec_mode = 1'b0;
  bit          res_busy = 1'b0;
  bit          res_now = 1'b0;
  int          res_cnt = 0;
  logic [31:0] res_pc = '0;
  bit          res_redirect = 1'b0;
  logic [31:0] res_target = '0;

  fetch_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .mem_req_o(mem_req),
    .mem_rsp_i(mem_rsp),
    .resolve_i(resolve),
    .ready_i  (ready),
    .out_o    (dut_out),
    .valid_o  (valid)
  );

  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    int          pick;
    r    = $random(seed);
    pick = $random(seed) & 15;
    if (pick < 9) begin
      rand_word = {r[31:7], 7'b0110011};
    end else if (pick < 11) begin
      rand_word = {r[31:7], 7'b0000011};
    end else if (pick < 13) begin
      rand_word = {r[31:7], 7'b1101111};
    end else if (pick < 15) begin
      rand_word = {r[31:7], 7'b1100011};
    end else begin
      rand_word = FENCE_I;
    end
  endfunction

  // jal and conditional branches
  function automatic bit is_branch_word(input logic [31:0] w);
    return (w[6:0] == 7'b1101111) || (w[6:0] == 7'b1100011);
  endfunction

  function automatic bit needs_resolve(input logic [31:0] w);
    return is_branch_word(w) || (w[6:0] == 7'b0000011) || (w == FENCE_I);
  endfunction

  task automatic log_mismatch(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED t=%0t %s: got %08h expected %08h", $time, what, got, exp);
  endtask

  // fresh words right behind the fence, seen only through a refill
  task automatic rewrite_after(input logic [31:0] pc);
    logic [7:0] idx;
    idx = pc[9:2];
    mem[idx + 8'd1] = rand_word();
    mem[idx + 8'd2] = rand_word();
    rewrites += 2;
  endtask

  task automatic accept_arch(input logic [31:0] w);
    logic [31:0] tw;
    if (!needs_resolve(w)) begin
      arch_pc = arch_pc + 4;
    end else begin
      tw           = $random(seed);
      res_busy     = 1'b1;
      res_cnt      = ($random(seed) & 255) % 6;
      res_pc       = arch_pc;
      res_redirect = is_branch_word(w) && (($random(seed) & 1) != 0);
      // repeating the last target lets some predictions hit
      if (btb_valid && (($random(seed) & 1) != 0)) begin
        res_target = btb;
      end else begin
        res_target = {22'd0, tw[7:0], 2'b00};
      end
      if (is_branch_word(w) && btb_valid) begin
        spec_mode = 1'b1;
        pred      = btb;
        spec_pc   = btb;
      end
      if (w == FENCE_I) begin
        rewrite_after(arch_pc);
      end
    end
  endtask

  task automatic check_transfer();
    logic [31:0] w;
    if (valid && ready) begin
      w = mem[dut_out.pc[9:2]];
      accepted++;
      checks += 2;
      assert (dut_out.inst == w) else log_mismatch("inst", dut_out.inst, w);
      if (spec_mode) begin
        assert (dut_out.spec && dut_out.pc == spec_pc)
          else log_mismatch("spec pc", dut_out.pc, spec_pc);
        assert (!needs_resolve(w) && w[6:0] != 7'b0100011)
          else begin
            errors++;
            $display("t=%0t branch, load, store or fence accepted under speculation",
                     $time);
          end
        spec_pc = spec_pc + 4;
      end else begin
        assert (!dut_out.spec && dut_out.pc == arch_pc)
          else log_mismatch("arch pc", dut_out.pc, arch_pc);
        accept_arch(w);
      end
    end
  endtask

  task automatic apply_resolve();
    logic [31:0] npc;
    npc = res_redirect ? res_target : res_pc + 4;
    if (res_redirect) begin
      btb       = res_target;
      btb_valid = 1'b1;
    end
    // a hit keeps the spec outputs, a miss kills them
    if (spec_mode && npc == pred) begin
      arch_pc = spec_pc;
    end else begin
      arch_pc = npc;
    end
    spec_mode = 1'b0;
    res_now   = 1'b0;
  endtask

  task automatic drive_memory();
    mem_rsp.valid <= 1'b0;
    if (mem_req.valid) begin
      checks++;
      assert (!rsp_busy)
        else begin
          errors++;
          $display("t=%0t memory request issued while another was outstanding", $time);
        end
      rsp_busy = 1'b1;
      rsp_cnt  = $random(seed) & 3;
      rsp_addr = mem_req.addr;
    end else if (rsp_busy && rsp_cnt > 0) begin
      rsp_cnt--;
    end
    if (rsp_busy && rsp_cnt == 0) begin
      mem_rsp.valid <= 1'b1;
      mem_rsp.data  <= mem[rsp_addr[9:2]];
      rsp_busy = 1'b0;
    end
  endtask

  task automatic drive_backend();
    resolve.valid <= 1'b0;
    ready         <= ($random(seed) & 3) != 0;
    if (res_busy) begin
      if (res_cnt == 0) begin
        resolve.valid    <= 1'b1;
        resolve.redirect <= res_redirect;
        resolve.target   <= res_target;
        res_busy = 1'b0;
        res_now  = 1'b1;
      end else begin
        res_cnt--;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycles++;
      check_transfer();
      // a held output keeps its spec flag, so the resolve waits for it
      if (res_now && !(valid && !ready)) begin
        apply_resolve();
      end
      drive_memory();
      drive_backend();
    end
  end

  initial begin
    rst = 1'b1;
    for (int i = 0; i < 256; i++) begin
      mem[i[7:0]] = rand_word();
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    while (accepted < N_INST && cycles < MAX_CYCLES) begin
      @(negedge clk);
    end
    if (accepted < N_INST) begin
      errors++;
      $display("timeout: only %0d of %0d instructions accepted in %0d cycles",
               accepted, N_INST, cycles);
    end
    errors += u_dut.u_ctrl.u_asserts.fail_cnt;
    $display("errors=%0d checks=%0d accepted=%0d rewritten=%0d cycles=%0d",
             errors, checks, accepted, rewrites, cycles);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/fetch_pkg.sv
logic/inst_decode.sv
logic/icache.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
sim/fetch_asserts.sv
sim/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= fetch_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended early"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
